// File: Makefile
VERILATOR ?= verilator
LINTFLAGS  = --lint-only --timing --assert
SIMFLAGS   = --binary --timing --assert -j 0
TOP        = riscvTop_tb
FILELIST   = filelist.f
OBJDIR     = obj_dir
LOG        = sim.log
FAIL_MSG   = sim failed

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	  echo "simulation FAILED, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: filelist.f
+incdir+hdl
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/registerFile.sv
hdl/executeStage.sv
hdl/memoryStage.sv
hdl/hazardUnit.sv
hdl/riscvTop.sv
sim/riscvTop_chk.sv
sim/riscvTop_tb.sv

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module decodeStage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    flush,
  input  logic [`RV_XLEN-1:0]     instrD,
  input  logic [`RV_XLEN-1:0]     pcD,
  input  logic [`RV_XLEN-1:0]     pcPlus4D,
  input  logic [`RV_XLEN-1:0]     rd1,
  input  logic [`RV_XLEN-1:0]     rd2,
  output logic [`RV_REG_AW-1:0]   rs1D,
  output logic [`RV_REG_AW-1:0]   rs2D,
  output logic                    regWriteE,
  output logic                    memWriteE,
  output logic                    memReadE,
  output rvPipePkg::resultSrcT    resultSrcE,
  output rvIsaPkg::aluOpT         aluOpE,
  output logic                    aluSrcImmE,
  output logic                    branchE,
  output logic                    branchNeE,
  output logic                    jumpE,
  output logic                    isLuiE,
  output logic                    isHaltE,
  output logic [`RV_XLEN-1:0]     rd1E,
  output logic [`RV_XLEN-1:0]     rd2E,
  output logic [`RV_REG_AW-1:0]   rs1E,
  output logic [`RV_REG_AW-1:0]   rs2E,
  output logic [`RV_REG_AW-1:0]   rdE,
  output logic [`RV_XLEN-1:0]     immE,
  output logic [`RV_XLEN-1:0]     pcE,
  output logic [`RV_XLEN-1:0]     pcPlus4E
);

  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic                     regWriteD, memWriteD, memReadD;
  logic                     aluSrcImmD, branchD, branchNeD, jumpD, isLuiD, isHaltD;
  logic                     useRs1, useRs2;
  rvPipePkg::resultSrcT     resultSrcD;
  rvIsaPkg::aluOpT          aluOpD;
  logic [`RV_XLEN-1:0]      immD;
  logic [`RV_REG_AW-1:0]    rdD;

  assign funct3 = instrD[14:12];
  assign funct7 = instrD[31:25];

  // Anything not matched leaves every control low and becomes a bubble
  always_comb begin
    regWriteD  = 1'b0;
    memWriteD  = 1'b0;
    memReadD   = 1'b0;
    resultSrcD = rvPipePkg::ALU;
    aluOpD     = rvIsaPkg::ADD;
    aluSrcImmD = 1'b0;
    branchD    = 1'b0;
    branchNeD  = 1'b0;
    jumpD      = 1'b0;
    isLuiD     = 1'b0;
    isHaltD    = 1'b0;
    useRs1     = 1'b0;
    useRs2     = 1'b0;
    immD       = '0;
    case (rvIsaPkg::opcodeT'(instrD[6:0]))
      rvIsaPkg::OP: begin
        useRs1    = 1'b1;
        useRs2    = 1'b1;
        regWriteD = 1'b1;
        case (funct3)
          rvIsaPkg::F3_ADD_SUB: begin
            aluOpD = (funct7 == rvIsaPkg::F7_SUB) ? rvIsaPkg::SUB : rvIsaPkg::ADD;
          end
          rvIsaPkg::F3_SLT: aluOpD = rvIsaPkg::SLT;
          rvIsaPkg::F3_XOR: aluOpD = rvIsaPkg::XOR;
          rvIsaPkg::F3_OR:  aluOpD = rvIsaPkg::OR;
          rvIsaPkg::F3_AND: aluOpD = rvIsaPkg::AND;
          default:          regWriteD = 1'b0;
        endcase
        if (funct7 != rvIsaPkg::F7_BASE &&
            !(funct3 == rvIsaPkg::F3_ADD_SUB && funct7 == rvIsaPkg::F7_SUB)) begin
          regWriteD = 1'b0;
        end
      end
      rvIsaPkg::OP_IMM: begin
        if (funct3 == rvIsaPkg::F3_ADD_SUB) begin
          useRs1     = 1'b1;
          regWriteD  = 1'b1;
          aluSrcImmD = 1'b1;
          immD       = {{20{instrD[31]}}, instrD[31:20]};
        end
      end
      rvIsaPkg::LOAD: begin
        if (funct3 == rvIsaPkg::F3_LW) begin
          useRs1     = 1'b1;
          regWriteD  = 1'b1;
          memReadD   = 1'b1;
          resultSrcD = rvPipePkg::MEM;
          aluSrcImmD = 1'b1;
          immD       = {{20{instrD[31]}}, instrD[31:20]};
        end
      end
      rvIsaPkg::STORE: begin
        if (funct3 == rvIsaPkg::F3_SW) begin
          useRs1     = 1'b1;
          useRs2     = 1'b1;
          memWriteD  = 1'b1;
          aluSrcImmD = 1'b1;
          immD       = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
        end
      end
      rvIsaPkg::BRANCH: begin
        if (funct3 == rvIsaPkg::F3_BEQ || funct3 == rvIsaPkg::F3_BNE) begin
          useRs1    = 1'b1;
          useRs2    = 1'b1;
          branchD   = 1'b1;
          branchNeD = (funct3 == rvIsaPkg::F3_BNE);
          immD      = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25],
                       instrD[11:8], 1'b0};
        end
      end
      rvIsaPkg::JAL: begin
        regWriteD  = 1'b1;
        jumpD      = 1'b1;
        resultSrcD = rvPipePkg::PC4;
        immD       = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20],
                      instrD[30:21], 1'b0};
      end
      rvIsaPkg::LUI: begin
        regWriteD = 1'b1;
        isLuiD    = 1'b1;
        aluOpD    = rvIsaPkg::PASSB;
        immD      = {instrD[31:12], 12'b0};
      end
      rvIsaPkg::SYSTEM: begin
        // Accept ecall only, where every other field is zero
        isHaltD = (instrD[31:7] == '0);
      end
      default: ;
    endcase
  end

  // Unused source fields read as x0 so they never forward or stall
  assign rs1D = useRs1 ? instrD[19:15] : '0;
  assign rs2D = useRs2 ? instrD[24:20] : '0;
  assign rdD  = regWriteD ? instrD[11:7] : '0;

  always_ff @(posedge clk) begin
    if (reset || stall || flush) begin
      regWriteE  <= 1'b0;
      memWriteE  <= 1'b0;
      memReadE   <= 1'b0;
      resultSrcE <= rvPipePkg::ALU;
      aluOpE     <= rvIsaPkg::ADD;
      aluSrcImmE <= 1'b0;
      branchE    <= 1'b0;
      branchNeE  <= 1'b0;
      jumpE      <= 1'b0;
      isLuiE     <= 1'b0;
      isHaltE    <= 1'b0;
      rs1E       <= '0;
      rs2E       <= '0;
      rdE        <= '0;
    end else begin
      regWriteE  <= regWriteD;
      memWriteE  <= memWriteD;
      memReadE   <= memReadD;
      resultSrcE <= resultSrcD;
      aluOpE     <= aluOpD;
      aluSrcImmE <= aluSrcImmD;
      branchE    <= branchD;
      branchNeE  <= branchNeD;
      jumpE      <= jumpD;
      isLuiE     <= isLuiD;
      isHaltE    <= isHaltD;
      rs1E       <= rs1D;
      rs2E       <= rs2D;
      rdE        <= rdD;
    end
  end

  // Operands and addresses
  always_ff @(posedge clk) begin
    rd1E     <= rd1;
    rd2E     <= rd2;
    immE     <= immD;
    pcE      <= pcD;
    pcPlus4E <= pcPlus4D;
  end

endmodule

// File: hdl/executeStage.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module executeStage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    regWriteE,
  input  logic                    memWriteE,
  input  logic                    memReadE,
  input  rvPipePkg::resultSrcT    resultSrcE,
  input  rvIsaPkg::aluOpT         aluOpE,
  input  logic                    aluSrcImmE,
  input  logic                    branchE,
  input  logic                    branchNeE,
  input  logic                    jumpE,
  input  logic                    isLuiE,
  input  logic                    isHaltE,
  input  logic [`RV_XLEN-1:0]     rd1E,
  input  logic [`RV_XLEN-1:0]     rd2E,
  input  logic [`RV_REG_AW-1:0]   rdE,
  input  logic [`RV_XLEN-1:0]     immE,
  input  logic [`RV_XLEN-1:0]     pcE,
  input  logic [`RV_XLEN-1:0]     pcPlus4E,
  input  rvPipePkg::fwdSelT       fwdA,
  input  rvPipePkg::fwdSelT       fwdB,
  input  logic [`RV_XLEN-1:0]     resultW,
  output logic                    redirect,
  output logic [`RV_XLEN-1:0]     redirectTarget,
  output logic                    regWriteM,
  output logic                    memWriteM,
  output logic                    memReadM,
  output rvPipePkg::resultSrcT    resultSrcM,
  output logic [`RV_REG_AW-1:0]   rdM,
  output logic [`RV_XLEN-1:0]     aluResultM,
  output logic [`RV_XLEN-1:0]     writeDataM,
  output logic [`RV_XLEN-1:0]     pcPlus4M,
  output logic                    isHaltM
);

  logic [`RV_XLEN-1:0] srcA, fwdValB, srcB, aluOut;
  logic                equal;

  always_comb begin
    case (fwdA)
      rvPipePkg::FROM_MEM: srcA = aluResultM;
      rvPipePkg::FROM_WB:  srcA = resultW;
      default:             srcA = rd1E;
    endcase
    case (fwdB)
      rvPipePkg::FROM_MEM: fwdValB = aluResultM;
      rvPipePkg::FROM_WB:  fwdValB = resultW;
      default:             fwdValB = rd2E;
    endcase
  end

  // lui takes its U immediate through operand B
  assign srcB = (aluSrcImmE || isLuiE) ? immE : fwdValB;

  always_comb begin
    case (aluOpE)
      rvIsaPkg::SUB:   aluOut = srcA - srcB;
      rvIsaPkg::AND:   aluOut = srcA & srcB;
      rvIsaPkg::OR:    aluOut = srcA | srcB;
      rvIsaPkg::XOR:   aluOut = srcA ^ srcB;
      rvIsaPkg::SLT:   aluOut = {{(`RV_XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
      rvIsaPkg::PASSB: aluOut = srcB;
      default:         aluOut = srcA + srcB;
    endcase
  end

  // Branch sense flips the equality test for bne
  assign equal          = (srcA == fwdValB);
  assign redirect       = jumpE || (branchE && (equal ^ branchNeE));
  assign redirectTarget = pcE + immE;

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteM  <= 1'b0;
      memWriteM  <= 1'b0;
      memReadM   <= 1'b0;
      resultSrcM <= rvPipePkg::ALU;
      rdM        <= '0;
      isHaltM    <= 1'b0;
    end else begin
      regWriteM  <= regWriteE;
      memWriteM  <= memWriteE;
      memReadM   <= memReadE;
      resultSrcM <= resultSrcE;
      rdM        <= rdE;
      isHaltM    <= isHaltE;
    end
  end

  always_ff @(posedge clk) begin
    aluResultM <= aluOut;
    writeDataM <= fwdValB;
    pcPlus4M   <= pcPlus4E;
  end

endmodule

// File: hdl/fetchStage.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module fetchStage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    flush,
  input  logic                    halt,
  input  logic                    redirect,
  input  logic [`RV_XLEN-1:0]     redirectTarget,
  input  logic                    imemWrite,
  input  logic [`RV_IMEM_AW-1:0]  imemAddr,
  input  logic [`RV_XLEN-1:0]     imemData,
  output logic [`RV_XLEN-1:0]     instrD,
  output logic [`RV_XLEN-1:0]     pcD,
  output logic [`RV_XLEN-1:0]     pcPlus4D
);

  logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
  logic [`RV_XLEN-1:0] pcF;
  logic [`RV_XLEN-1:0] pcPlus4F;
  logic [`RV_XLEN-1:0] instrF;

  assign pcPlus4F = pcF + `RV_XLEN'd4;
  assign instrF   = imem[pcF[`RV_IMEM_AW+1:2]];

  // Program loading only happens while the core is held in reset
  always_ff @(posedge clk) begin
    if (reset && imemWrite) begin
      imem[imemAddr] <= imemData;
    end
  end

  // Halt outranks a redirect from a younger instruction
  always_ff @(posedge clk) begin
    if (reset) begin
      pcF <= '0;
    end else if (halt) begin
      pcF <= pcF;
    end else if (redirect) begin
      pcF <= redirectTarget;
    end else if (!stall) begin
      pcF <= pcPlus4F;
    end
  end

  // An all-zero word decodes as a bubble
  always_ff @(posedge clk) begin
    if (reset || flush || halt) begin
      instrD <= '0;
    end else if (!stall) begin
      instrD   <= instrF;
      pcD      <= pcF;
      pcPlus4D <= pcPlus4F;
    end
  end

endmodule

// File: hdl/hazardUnit.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module hazardUnit (
  input  logic                    clk,
  input  logic [`RV_REG_AW-1:0]   rs1D,
  input  logic [`RV_REG_AW-1:0]   rs2D,
  input  logic [`RV_REG_AW-1:0]   rs1E,
  input  logic [`RV_REG_AW-1:0]   rs2E,
  input  logic [`RV_REG_AW-1:0]   rdE,
  input  logic                    memReadE,
  input  logic [`RV_REG_AW-1:0]   rdM,
  input  logic                    regWriteM,
  input  logic [`RV_REG_AW-1:0]   rdW,
  input  logic                    regWriteW,
  input  logic                    redirect,
  output rvPipePkg::fwdSelT       fwdA,
  output rvPipePkg::fwdSelT       fwdB,
  output logic                    stall,
  output logic                    flush
);

  // Youngest producer wins, x0 is never a source
  function automatic rvPipePkg::fwdSelT pickFwd(
    input logic [`RV_REG_AW-1:0] rs,
    input logic [`RV_REG_AW-1:0] rdMem,
    input logic                  wrMem,
    input logic [`RV_REG_AW-1:0] rdWb,
    input logic                  wrWb
  );
    if (rs != '0 && wrMem && rdMem == rs) begin
      return rvPipePkg::FROM_MEM;
    end else if (rs != '0 && wrWb && rdWb == rs) begin
      return rvPipePkg::FROM_WB;
    end
    return rvPipePkg::REG;
  endfunction

  assign fwdA = pickFwd(rs1E, rdM, regWriteM, rdW, regWriteW);
  assign fwdB = pickFwd(rs2E, rdM, regWriteM, rdW, regWriteW);

  // Load result is not ready until writeback, hold the consumer one cycle
  assign stall = memReadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);
  assign flush = redirect;

endmodule

// File: hdl/memoryStage.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module memoryStage (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    regWriteM,
  input  logic                    memWriteM,
  input  logic                    memReadM,
  input  rvPipePkg::resultSrcT    resultSrcM,
  input  logic [`RV_REG_AW-1:0]   rdM,
  input  logic [`RV_XLEN-1:0]     aluResultM,
  input  logic [`RV_XLEN-1:0]     writeDataM,
  input  logic [`RV_XLEN-1:0]     pcPlus4M,
  input  logic                    isHaltM,
  output logic [`RV_REG_AW-1:0]   rdW,
  output logic                    regWriteW,
  output logic [`RV_XLEN-1:0]     resultW,
  output logic                    halted
);

  logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] wordAddr;
  logic [`RV_XLEN-1:0]    readData;
  logic [`RV_XLEN-1:0]    resultM;
  logic                   haltSticky;

  // Word index, low two bits ignored
  assign wordAddr = aluResultM[`RV_DMEM_AW+1:2];
  assign readData = memReadM ? dmem[wordAddr] : '0;

  always_ff @(posedge clk) begin
    if (memWriteM) begin
      dmem[wordAddr] <= writeDataM;
    end
  end

  always_comb begin
    case (resultSrcM)
      rvPipePkg::MEM: resultM = readData;
      rvPipePkg::PC4: resultM = pcPlus4M;
      default:        resultM = aluResultM;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      regWriteW  <= 1'b0;
      rdW        <= '0;
      haltSticky <= 1'b0;
    end else begin
      regWriteW  <= regWriteM;
      rdW        <= rdM;
      haltSticky <= haltSticky | isHaltM;
    end
    resultW <= resultM;
  end

  // Rises as soon as the ecall is here and holds until reset
  assign halted = haltSticky | isHaltM;

endmodule

// File: hdl/registerFile.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module registerFile (
  input  logic                    clk,
  input  logic                    reset,
  input  logic [`RV_REG_AW-1:0]   rs1,
  input  logic [`RV_REG_AW-1:0]   rs2,
  input  logic [`RV_REG_AW-1:0]   rdW,
  input  logic                    regWriteW,
  input  logic [`RV_XLEN-1:0]     resultW,
  output logic [`RV_XLEN-1:0]     rd1,
  output logic [`RV_XLEN-1:0]     rd2,
  output logic [`RV_XLEN-1:0]     a0
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 2**`RV_REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (regWriteW && rdW != '0) begin
      regs[rdW] <= resultW;
    end
  end

  // Same-cycle write is visible to decode
  assign rd1 = (rs1 == '0) ? '0 :
               (regWriteW && rdW == rs1) ? resultW : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 :
               (regWriteW && rdW == rs2) ? resultW : regs[rs2];

  assign a0 = regs[10];

endmodule

// File: hdl/riscvTop.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscvTop (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    imemWrite,
  input  logic [`RV_IMEM_AW-1:0]  imemAddr,
  input  logic [`RV_XLEN-1:0]     imemData,
  output logic [`RV_XLEN-1:0]     a0,
  output logic                    halted
);

  // Fetch to decode
  logic [`RV_XLEN-1:0]   instrD, pcD, pcPlus4D;

  // Decode and register file
  logic [`RV_REG_AW-1:0] rs1D, rs2D;
  logic [`RV_XLEN-1:0]   rd1, rd2;

  // Decode to execute
  logic                  regWriteE, memWriteE, memReadE, aluSrcImmE;
  logic                  branchE, branchNeE, jumpE, isLuiE, isHaltE;
  rvPipePkg::resultSrcT  resultSrcE;
  rvIsaPkg::aluOpT       aluOpE;
  logic [`RV_XLEN-1:0]   rd1E, rd2E, immE, pcE, pcPlus4E;
  logic [`RV_REG_AW-1:0] rs1E, rs2E, rdE;

  // Execute to memory
  logic                  redirect;
  logic [`RV_XLEN-1:0]   redirectTarget;
  logic                  regWriteM, memWriteM, memReadM, isHaltM;
  rvPipePkg::resultSrcT  resultSrcM;
  logic [`RV_REG_AW-1:0] rdM;
  logic [`RV_XLEN-1:0]   aluResultM, writeDataM, pcPlus4M;

  // Writeback
  logic [`RV_REG_AW-1:0] rdW;
  logic                  regWriteW;
  logic [`RV_XLEN-1:0]   resultW;

  // Hazard control
  rvPipePkg::fwdSelT     fwdA, fwdB;
  logic                  stall, flush;

  fetchStage u_fetch (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .halt(halted),
    .redirect(redirect), .redirectTarget(redirectTarget),
    .imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
    .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D)
  );

  decodeStage u_decode (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .instrD(instrD), .pcD(pcD), .pcPlus4D(pcPlus4D), .rd1(rd1), .rd2(rd2),
    .rs1D(rs1D), .rs2D(rs2D),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .memReadE(memReadE),
    .resultSrcE(resultSrcE), .aluOpE(aluOpE), .aluSrcImmE(aluSrcImmE),
    .branchE(branchE), .branchNeE(branchNeE), .jumpE(jumpE),
    .isLuiE(isLuiE), .isHaltE(isHaltE), .rd1E(rd1E), .rd2E(rd2E),
    .rs1E(rs1E), .rs2E(rs2E), .rdE(rdE), .immE(immE),
    .pcE(pcE), .pcPlus4E(pcPlus4E)
  );

  registerFile u_regFile (
    .clk(clk), .reset(reset), .rs1(rs1D), .rs2(rs2D),
    .rdW(rdW), .regWriteW(regWriteW), .resultW(resultW),
    .rd1(rd1), .rd2(rd2), .a0(a0)
  );

  executeStage u_execute (
    .clk(clk), .reset(reset),
    .regWriteE(regWriteE), .memWriteE(memWriteE), .memReadE(memReadE),
    .resultSrcE(resultSrcE), .aluOpE(aluOpE), .aluSrcImmE(aluSrcImmE),
    .branchE(branchE), .branchNeE(branchNeE), .jumpE(jumpE),
    .isLuiE(isLuiE), .isHaltE(isHaltE), .rd1E(rd1E), .rd2E(rd2E),
    .rdE(rdE), .immE(immE), .pcE(pcE), .pcPlus4E(pcPlus4E),
    .fwdA(fwdA), .fwdB(fwdB), .resultW(resultW),
    .redirect(redirect), .redirectTarget(redirectTarget),
    .regWriteM(regWriteM), .memWriteM(memWriteM), .memReadM(memReadM),
    .resultSrcM(resultSrcM), .rdM(rdM), .aluResultM(aluResultM),
    .writeDataM(writeDataM), .pcPlus4M(pcPlus4M), .isHaltM(isHaltM)
  );

  memoryStage u_memory (
    .clk(clk), .reset(reset),
    .regWriteM(regWriteM), .memWriteM(memWriteM), .memReadM(memReadM),
    .resultSrcM(resultSrcM), .rdM(rdM), .aluResultM(aluResultM),
    .writeDataM(writeDataM), .pcPlus4M(pcPlus4M), .isHaltM(isHaltM),
    .rdW(rdW), .regWriteW(regWriteW), .resultW(resultW), .halted(halted)
  );

  hazardUnit u_hazard (
    .clk(clk),
    .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
    .rdE(rdE), .memReadE(memReadE),
    .rdM(rdM), .regWriteM(regWriteM), .rdW(rdW), .regWriteW(regWriteW),
    .redirect(redirect),
    .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
  );

endmodule

// File: hdl/riscv_params.svh
`ifndef RISCV_PARAMS_SVH
`define RISCV_PARAMS_SVH

// Datapath and register index widths
`define RV_XLEN 32
`define RV_REG_AW 5

// Word-addressed memories
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256
`define RV_IMEM_AW ($clog2(`RV_IMEM_WORDS))
`define RV_DMEM_AW ($clog2(`RV_DMEM_WORDS))

`endif

// File: hdl/rvIsaPkg.sv
package rvIsaPkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    LUI    = 7'b0110111,
    SYSTEM = 7'b1110011
  } opcodeT;

  // Operations the execute ALU can perform
  typedef enum logic [3:0] {
    ADD   = 4'd0,
    SUB   = 4'd1,
    AND   = 4'd2,
    OR    = 4'd3,
    XOR   = 4'd4,
    SLT   = 4'd5,
    PASSB = 4'd6
  } aluOpT;

  // funct3 values for register and immediate arithmetic
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct3 values for memory access and branches
  localparam logic [2:0] F3_LW  = 3'b010;
  localparam logic [2:0] F3_SW  = 3'b010;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;

  // funct7 separates add from sub
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

endpackage

// File: hdl/rvPipePkg.sv
package rvPipePkg;

  // Source of the value written back to the register file
  typedef enum logic [1:0] {
    ALU = 2'd0,
    MEM = 2'd1,
    PC4 = 2'd2
  } resultSrcT;

  // Operand source in execute
  typedef enum logic [1:0] {
    REG      = 2'd0,
    FROM_MEM = 2'd1,
    FROM_WB  = 2'd2
  } fwdSelT;

endpackage

// File: sim/riscvTop_chk.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscvTop_chk (
  input logic                  clk,
  input logic                  reset,
  input logic                  stall,
  input logic                  flush,
  input logic                  halted,
  input rvPipePkg::fwdSelT     fwdA,
  input rvPipePkg::fwdSelT     fwdB,
  input logic [`RV_REG_AW-1:0] rs1E,
  input logic [`RV_REG_AW-1:0] rs2E
);

  // A load in execute is never a branch or jump
  stallFlushExclusive: assert property (@(posedge clk) disable iff (reset)
    !(stall && flush))
    else $error("stall and flush are high in the same cycle");

  // Sticky until a reset edge has been seen
  haltedHolds: assert property (@(posedge clk) $fell(halted) |-> $past(reset))
    else $error("halted fell while reset was low");

  noForwardFromX0A: assert property (@(posedge clk) disable iff (reset)
    (fwdA != rvPipePkg::REG) |-> (rs1E != '0))
    else $error("operand A forwarded for register x0");

  noForwardFromX0B: assert property (@(posedge clk) disable iff (reset)
    (fwdB != rvPipePkg::REG) |-> (rs2E != '0))
    else $error("operand B forwarded for register x0");

endmodule

// Hazard unit and memory stage outputs as seen in the top
bind riscvTop riscvTop_chk u_chk (
  .clk(clk), .reset(reset), .stall(stall), .flush(flush), .halted(halted),
  .fwdA(fwdA), .fwdB(fwdB), .rs1E(rs1E), .rs2E(rs2E)
);

// File: sim/riscvTop_tb.sv
`timescale 1ns/1ps
`include "riscv_params.svh"

module riscvTop_tb;

  logic                   clk;
  logic                   reset;
  logic                   imemWrite;
  logic [`RV_IMEM_AW-1:0] imemAddr;
  logic [`RV_XLEN-1:0]    imemData;
  logic [`RV_XLEN-1:0]    a0;
  logic                   halted;

  // Program image and architectural register model of the current test
  logic [`RV_XLEN-1:0] prog [$];
  logic [`RV_XLEN-1:0] refRegs [32];
  logic [15:0]         lfsrState;

  riscvTop u_dut (
    .clk(clk), .reset(reset),
    .imemWrite(imemWrite), .imemAddr(imemAddr), .imemData(imemData),
    .a0(a0), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Instruction encoders
  function automatic logic [31:0] aluReg(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rvIsaPkg::OP};
  endfunction

  function automatic logic [31:0] addImm(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, rvIsaPkg::F3_ADD_SUB, rd, rvIsaPkg::OP_IMM};
  endfunction

  function automatic logic [31:0] loadWord(input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [11:0] imm);
    return {imm, rs1, rvIsaPkg::F3_LW, rd, rvIsaPkg::LOAD};
  endfunction

  function automatic logic [31:0] storeWord(input logic [4:0] rs2, input logic [4:0] rs1,
                                            input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, rvIsaPkg::F3_SW, imm[4:0], rvIsaPkg::STORE};
  endfunction

  function automatic logic [31:0] branchOp(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::BRANCH};
  endfunction

  function automatic logic [31:0] jumpLink(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::JAL};
  endfunction

  function automatic logic [31:0] upperImm(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, rvIsaPkg::LUI};
  endfunction

  function automatic logic [31:0] envCall();
    return {25'b0, rvIsaPkg::SYSTEM};
  endfunction

  // Reference results straight from the RV32I definitions
  function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic [6:0] f7,
                                         input logic [31:0] a, input logic [31:0] b);
    case (f3)
      rvIsaPkg::F3_ADD_SUB: return (f7 == rvIsaPkg::F7_SUB) ? a - b : a + b;
      rvIsaPkg::F3_SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rvIsaPkg::F3_XOR:     return a ^ b;
      rvIsaPkg::F3_OR:      return a | b;
      rvIsaPkg::F3_AND:     return a & b;
      default:              return 32'd0;
    endcase
  endfunction

  // Fibonacci LFSR with taps 16 14 13 11
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
    lfsrState = {lfsrState[14:0], fb};
    return fb;
  endfunction

  function automatic logic [11:0] randImm12();
    logic [11:0] value;
    value = '0;
    for (int i = 0; i < 12; i++) begin
      value = {value[10:0], lfsrBit()};
    end
    return value;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    assert (actual === expected) else
      failRun($sformatf("error: time %0t %s expected 0x%08h actual 0x%08h",
                        $time, name, expected, actual));
  endtask

  task automatic clearModel();
    for (int i = 0; i < 32; i++) begin
      refRegs[i] = '0;
    end
  endtask

  // Add an instruction to the program and update the model with its effect
  task automatic appendAddi(input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [11:0] imm);
    prog.push_back(addImm(rd, rs1, imm));
    if (rd != 5'd0) begin
      refRegs[rd] = refRegs[rs1] + {{20{imm[11]}}, imm};
    end
  endtask

  task automatic queueAluOp(input logic [2:0] f3, input logic [6:0] f7, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2);
    prog.push_back(aluReg(f3, f7, rd, rs1, rs2));
    if (rd != 5'd0) begin
      refRegs[rd] = aluRef(f3, f7, refRegs[rs1], refRegs[rs2]);
    end
  endtask

  // Holds reset for at least ten cycles and longer when the program needs more loader cycles
  task automatic loadProgram();
    int cycles;
    @(posedge clk);
    #1;
    reset = 1'b1;
    // Two nops behind the ecall still flow down the pipe
    prog.push_back(32'h0);
    prog.push_back(32'h0);
    cycles = 0;
    foreach (prog[i]) begin
      imemWrite = 1'b1;
      imemAddr  = `RV_IMEM_AW'(i);
      imemData  = prog[i];
      @(posedge clk);
      #1;
      cycles++;
    end
    imemWrite = 1'b0;
    while (cycles < 10) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    checkValue("halted", {31'b0, halted}, 32'd0);
    checkValue("a0", a0, 32'd0);
  endtask

  task automatic waitHalted(input string name);
    int cycles;
    cycles = 0;
    while (halted !== 1'b1 && cycles < 200) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (halted === 1'b1) else
      failRun($sformatf("timeout: %s did not raise halted within 200 cycles", name));
  endtask

  task automatic runProgram(input string name, input logic [31:0] expected);
    loadProgram();
    reset = 1'b0;
    waitHalted(name);
    // The instruction ahead of the ecall writes back on the next edge
    @(posedge clk);
    #1;
    checkValue("a0", a0, expected);
    $display("%s finished with a0 = 0x%08h", name, a0);
  endtask

  // Dependent chain using both forwarding paths
  task automatic aluChainTest();
    clearModel();
    prog.delete();
    appendAddi(5'd5, 5'd0, 12'd23);
    appendAddi(5'd6, 5'd0, 12'hA35);
    queueAluOp(rvIsaPkg::F3_ADD_SUB, rvIsaPkg::F7_BASE, 5'd7, 5'd5, 5'd6);
    queueAluOp(rvIsaPkg::F3_ADD_SUB, rvIsaPkg::F7_SUB, 5'd8, 5'd7, 5'd5);
    queueAluOp(rvIsaPkg::F3_XOR, rvIsaPkg::F7_BASE, 5'd9, 5'd8, 5'd7);
    queueAluOp(rvIsaPkg::F3_OR, rvIsaPkg::F7_BASE, 5'd11, 5'd9, 5'd5);
    queueAluOp(rvIsaPkg::F3_AND, rvIsaPkg::F7_BASE, 5'd12, 5'd11, 5'd8);
    queueAluOp(rvIsaPkg::F3_SLT, rvIsaPkg::F7_BASE, 5'd13, 5'd8, 5'd5);
    queueAluOp(rvIsaPkg::F3_ADD_SUB, rvIsaPkg::F7_BASE, 5'd10, 5'd12, 5'd13);
    prog.push_back(envCall());
    runProgram("alu chain", refRegs[10]);
  endtask

  task automatic loadUseTest();
    prog.delete();
    prog.push_back(addImm(5'd5, 5'd0, 12'd100));
    prog.push_back(addImm(5'd6, 5'd0, 12'd64));
    prog.push_back(storeWord(5'd5, 5'd6, 12'd8));
    prog.push_back(loadWord(5'd7, 5'd6, 12'd8));
    prog.push_back(addImm(5'd10, 5'd7, 12'd37));
    prog.push_back(envCall());
    runProgram("load use", 32'd100 + 32'd37);
  endtask

  // Taken beq skips two corrupting addi and bne falls through
  task automatic branchFlushTest();
    prog.delete();
    prog.push_back(addImm(5'd10, 5'd0, 12'd5));
    prog.push_back(addImm(5'd5, 5'd0, 12'd5));
    prog.push_back(branchOp(rvIsaPkg::F3_BEQ, 5'd10, 5'd5, 13'd12));
    prog.push_back(addImm(5'd10, 5'd10, 12'd100));
    prog.push_back(addImm(5'd10, 5'd10, 12'd200));
    prog.push_back(branchOp(rvIsaPkg::F3_BNE, 5'd10, 5'd5, 13'd8));
    prog.push_back(addImm(5'd10, 5'd10, 12'd7));
    prog.push_back(envCall());
    runProgram("branch flush", 32'd5 + 32'd7);
  endtask

  task automatic jalLuiTest();
    logic [31:0] jalAddr;
    logic [31:0] luiValue;
    jalAddr  = 32'd4;
    luiValue = {20'h12345, 12'h000};
    prog.delete();
    prog.push_back(upperImm(5'd6, 20'h12345));
    prog.push_back(jumpLink(5'd11, 21'd8));
    // Skipped by the jal, it would corrupt the link register
    prog.push_back(addImm(5'd11, 5'd11, 12'd100));
    prog.push_back(aluReg(rvIsaPkg::F3_ADD_SUB, rvIsaPkg::F7_BASE, 5'd10, 5'd11, 5'd6));
    prog.push_back(envCall());
    runProgram("jal and lui", jalAddr + 32'd4 + luiValue);
  endtask

  task automatic randomAddiTest();
    logic [11:0] imm;
    clearModel();
    prog.delete();
    for (int i = 0; i < 7; i++) begin
      imm = randImm12();
      appendAddi(5'd10, (i == 0) ? 5'd0 : 5'd10, imm);
    end
    prog.push_back(envCall());
    runProgram("random addi", refRegs[10]);
  endtask

  task automatic midRunResetTest();
    prog.delete();
    prog.push_back(addImm(5'd10, 5'd0, 12'd1));
    repeat (5) prog.push_back(addImm(5'd10, 5'd10, 12'd1));
    prog.push_back(envCall());
    loadProgram();
    reset = 1'b0;
    // Two addi have retired by now and the ecall is still in the front end
    repeat (6) begin
      @(posedge clk);
      #1;
    end
    assert (halted === 1'b0) else
      failRun("halted rose before the mid-run reset was applied");
    checkValue("a0", a0, 32'd2);
    prog.delete();
    prog.push_back(addImm(5'd10, 5'd0, 12'd321));
    prog.push_back(addImm(5'd10, 5'd10, 12'hFEB));
    prog.push_back(envCall());
    runProgram("mid-run reset", 32'd300);
  endtask

  initial begin
    reset     = 1'b1;
    imemWrite = 1'b0;
    imemAddr  = '0;
    imemData  = '0;
    lfsrState = 16'd58870;
    aluChainTest();
    loadUseTest();
    branchFlushTest();
    jalLuiTest();
    randomAddiTest();
    midRunResetTest();
    $display("sim passed");
    $finish;
  end

endmodule
